/* files.f */
rtl/uart_bridge_pkg.sv
rtl/uart_link_if.sv
rtl/uart_apb_regs.sv
rtl/uart_cmd_seq.sv
rtl/uart_frame_tx.sv
rtl/uart_frame_rx.sv
rtl/uart_bridge_top.sv
tb/tb_clk_gen.sv
tb/uart_bridge_checker.sv
tb/uart_bridge_tb.sv

/* rtl/uart_apb_regs.sv */
`timescale 1ns/1ps

module uart_apb_regs
  import uart_bridge_pkg::*;
(
  input  logic                  clk,
  input  logic                  rst_n,
  input  logic                  psel,
  input  logic                  penable,
  input  logic                  pwrite,
  input  logic [3:0]            paddr,
  input  logic [31:0]           pwdata,
  output logic [31:0]           prdata,
  output logic                  pready,
  output logic                  pslverr,
  output logic                  cmd_start,
  output logic [CMD_WIDTH-1:0]  cmd_word,
  input  logic                  seq_busy,
  input  logic                  seq_done,
  input  logic [BYTE_WIDTH-1:0] resp_byte,
  input  logic                  resp_perr,
  input  logic                  resp_tmo
);

  logic                  access;
  logic                  addr_ok;
  logic                  busy;
  logic                  wr_cmd;
  logic                  wr_cmd_ok;
  logic                  done_q;
  logic                  perr_q;
  logic                  tmo_q;
  logic [BYTE_WIDTH-1:0] rdata_q;
  logic [31:0]           status;

  assign access  = psel & penable;
  assign addr_ok = (paddr == REG_CMD) || (paddr == REG_STATUS) || (paddr == REG_RDATA);
  assign busy    = seq_busy | cmd_start;  // covers the cycle before the sequencer leaves idle

  assign wr_cmd    = access & pwrite & (paddr == REG_CMD);
  assign wr_cmd_ok = wr_cmd & ~busy;

  assign pready  = 1'b1;
  assign pslverr = access & (~addr_ok | (wr_cmd & busy));

  always_comb
  begin
    status          = '0;
    status[ST_BUSY] = busy;
    status[ST_DONE] = done_q;
    status[ST_PERR] = perr_q;
    status[ST_TMO]  = tmo_q;
  end

  always_comb
  begin
    case (paddr)
      REG_CMD:    prdata = {{(32-CMD_WIDTH){1'b0}}, cmd_word};
      REG_STATUS: prdata = status;
      REG_RDATA:  prdata = {{(32-BYTE_WIDTH){1'b0}}, rdata_q};
      default:    prdata = '0;
    endcase
  end

  // ############################################################
  // start pulse and sticky status
  // ############################################################
  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      cmd_start <= 1'b0;
      done_q    <= 1'b0;
      perr_q    <= 1'b0;
      tmo_q     <= 1'b0;
    end
    else
    begin
      cmd_start <= wr_cmd_ok;
      if (wr_cmd_ok)
      begin
        done_q <= 1'b0;  // new command clears old results
        perr_q <= 1'b0;
        tmo_q  <= 1'b0;
      end
      else if (seq_done)
      begin
        done_q <= 1'b1;
        perr_q <= resp_perr;
        tmo_q  <= resp_tmo;
      end
    end
  end

  always_ff @(posedge clk)
  begin
    if (wr_cmd_ok)
      cmd_word <= pwdata[CMD_WIDTH-1:0];
    if (seq_done)
      rdata_q <= resp_byte;  // a write leaves the byte unchanged
  end

endmodule

/* rtl/uart_bridge_pkg.sv */
package uart_bridge_pkg;

  // ############################################################
  // command and frame widths
  // ############################################################
  localparam int CMD_WIDTH  = 16;
  localparam int BYTE_WIDTH = 8;
  localparam int ADDR_BITS  = 7;
  localparam int WRITE_BIT  = 15;  // 1 = write, 0 = read

  // ############################################################
  // apb register map and status bits
  // ############################################################
  localparam logic [3:0] REG_CMD    = 4'h0;
  localparam logic [3:0] REG_STATUS = 4'h4;
  localparam logic [3:0] REG_RDATA  = 4'h8;

  localparam int ST_BUSY = 0;
  localparam int ST_DONE = 1;
  localparam int ST_PERR = 2;
  localparam int ST_TMO  = 3;

  // command sequencer states
  typedef enum logic [2:0] {
    SEQ_IDLE,
    SEQ_SEND_HI,
    SEQ_GAP,
    SEQ_SEND_LO,
    SEQ_WAIT_RESP,
    SEQ_FINISH
  } seq_state_t;

endpackage

/* rtl/uart_bridge_top.sv */
`timescale 1ns/1ps

module uart_bridge_top
  import uart_bridge_pkg::*;
#(
  parameter int CLKS_PER_BIT = 434,
  parameter int GAP_CYCLES   = 100,
  parameter int RESP_TIMEOUT = 8000
) (
  input  logic        clk,
  input  logic        rst_n,
  input  logic        psel,
  input  logic        penable,
  input  logic        pwrite,
  input  logic [3:0]  paddr,
  input  logic [31:0] pwdata,
  output logic [31:0] prdata,
  output logic        pready,
  output logic        pslverr,
  output logic        txd,
  input  logic        rxd
);

  logic                  cmd_start;
  logic [CMD_WIDTH-1:0]  cmd_word;
  logic                  seq_busy;
  logic                  seq_done;
  logic [BYTE_WIDTH-1:0] resp_byte;
  logic                  resp_perr;
  logic                  resp_tmo;

  uart_link_if link ();

  uart_apb_regs uart_apb_regs_inst (
    .clk       (clk),
    .rst_n     (rst_n),
    .psel      (psel),
    .penable   (penable),
    .pwrite    (pwrite),
    .paddr     (paddr),
    .pwdata    (pwdata),
    .prdata    (prdata),
    .pready    (pready),
    .pslverr   (pslverr),
    .cmd_start (cmd_start),
    .cmd_word  (cmd_word),
    .seq_busy  (seq_busy),
    .seq_done  (seq_done),
    .resp_byte (resp_byte),
    .resp_perr (resp_perr),
    .resp_tmo  (resp_tmo)
  );

  uart_cmd_seq #(
    .GAP_CYCLES   (GAP_CYCLES),
    .RESP_TIMEOUT (RESP_TIMEOUT)
  ) uart_cmd_seq_inst (
    .clk       (clk),
    .rst_n     (rst_n),
    .cmd_start (cmd_start),
    .cmd_word  (cmd_word),
    .seq_busy  (seq_busy),
    .seq_done  (seq_done),
    .resp_byte (resp_byte),
    .resp_perr (resp_perr),
    .resp_tmo  (resp_tmo),
    .link      (link.seq)
  );

  uart_frame_tx #(
    .CLKS_PER_BIT (CLKS_PER_BIT)
  ) uart_frame_tx_inst (
    .clk   (clk),
    .rst_n (rst_n),
    .link  (link.tx),
    .txd   (txd)
  );

  uart_frame_rx #(
    .CLKS_PER_BIT (CLKS_PER_BIT)
  ) uart_frame_rx_inst (
    .clk   (clk),
    .rst_n (rst_n),
    .link  (link.rx),
    .rxd   (rxd)
  );

endmodule

/* rtl/uart_cmd_seq.sv */
`timescale 1ns/1ps

module uart_cmd_seq
  import uart_bridge_pkg::*;
#(
  parameter int GAP_CYCLES   = 100,
  parameter int RESP_TIMEOUT = 8000
) (
  input  logic                  clk,
  input  logic                  rst_n,
  input  logic                  cmd_start,
  input  logic [CMD_WIDTH-1:0]  cmd_word,
  output logic                  seq_busy,
  output logic                  seq_done,
  output logic [BYTE_WIDTH-1:0] resp_byte,
  output logic                  resp_perr,
  output logic                  resp_tmo,
  uart_link_if.seq              link
);

  localparam int CNT_MAX = (GAP_CYCLES > RESP_TIMEOUT) ? GAP_CYCLES : RESP_TIMEOUT;
  localparam int CNT_W   = $clog2(CNT_MAX + 1);

  localparam logic [CNT_W-1:0] GAP_LOAD = CNT_W'(GAP_CYCLES - 1);
  localparam logic [CNT_W-1:0] TMO_LOAD = CNT_W'(RESP_TIMEOUT - 1);

  seq_state_t            state;
  logic [CMD_WIDTH-1:0]  cmd_q;
  logic [CNT_W-1:0]      cnt;  // shared by gap and response timeout
  logic                  tx_start_q;
  logic [BYTE_WIDTH-1:0] tx_byte_q;
  logic                  rx_arm_q;

  assign seq_busy      = (state != SEQ_IDLE);
  assign seq_done      = (state == SEQ_FINISH);
  assign link.tx_start = tx_start_q;
  assign link.tx_byte  = tx_byte_q;
  assign link.rx_arm   = rx_arm_q;

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      state      <= SEQ_IDLE;
      cnt        <= '0;
      tx_start_q <= 1'b0;
      rx_arm_q   <= 1'b0;
      resp_perr  <= 1'b0;
      resp_tmo   <= 1'b0;
    end
    else
    begin
      tx_start_q <= 1'b0;
      case (state)
        SEQ_IDLE:
        begin
          if (cmd_start)
          begin
            tx_start_q <= 1'b1;
            resp_perr  <= 1'b0;
            resp_tmo   <= 1'b0;
            state      <= SEQ_SEND_HI;
          end
        end
        SEQ_SEND_HI, SEQ_SEND_LO:
        begin
          // tx_busy is still low while the start pulse is out
          if (!tx_start_q && !link.tx_busy)
          begin
            cnt   <= GAP_LOAD;
            state <= (state == SEQ_SEND_HI) ? SEQ_GAP : SEQ_FINISH;
          end
        end
        SEQ_GAP:
        begin
          if (cnt != '0)
            cnt <= cnt - 1'b1;
          else if (cmd_q[WRITE_BIT])
          begin
            tx_start_q <= 1'b1;
            state      <= SEQ_SEND_LO;
          end
          else
          begin
            rx_arm_q <= 1'b1;
            cnt      <= TMO_LOAD;
            state    <= SEQ_WAIT_RESP;
          end
        end
        SEQ_WAIT_RESP:
        begin
          if (link.rx_valid)
          begin
            resp_perr <= link.rx_perr;
            rx_arm_q  <= 1'b0;
            state     <= SEQ_FINISH;
          end
          else if (cnt == '0)
          begin
            resp_tmo <= 1'b1;  // no response
            rx_arm_q <= 1'b0;
            state    <= SEQ_FINISH;
          end
          else
            cnt <= cnt - 1'b1;
        end
        default:
          state <= SEQ_IDLE;  // finish lasts one cycle
      endcase
    end
  end

  // ############################################################
  // command and payload latches
  // ############################################################
  always_ff @(posedge clk)
  begin
    if (state == SEQ_IDLE && cmd_start)
    begin
      cmd_q     <= cmd_word;
      tx_byte_q <= {cmd_word[WRITE_BIT], cmd_word[WRITE_BIT-1 -: ADDR_BITS]};
    end
    else if (state == SEQ_GAP && cnt == '0)
      tx_byte_q <= cmd_q[BYTE_WIDTH-1:0];  // low byte for a write
    if (state == SEQ_WAIT_RESP && link.rx_valid)
      resp_byte <= link.rx_byte;
  end

endmodule

/* rtl/uart_frame_rx.sv */
`timescale 1ns/1ps

module uart_frame_rx
  import uart_bridge_pkg::*;
#(
  parameter int CLKS_PER_BIT = 434
) (
  input  logic   clk,
  input  logic   rst_n,
  uart_link_if.rx link,
  input  logic   rxd
);

  localparam int BAUD_W = $clog2(CLKS_PER_BIT);

  localparam logic [BAUD_W-1:0] BAUD_MAX = BAUD_W'(CLKS_PER_BIT - 1);
  localparam logic [BAUD_W-1:0] HALF     = BAUD_W'(CLKS_PER_BIT / 2);
  localparam logic [3:0]        PAR_BIT  = 4'(BYTE_WIDTH + 1);
  localparam logic [3:0]        STOP_BIT = 4'(BYTE_WIDTH + 2);

  logic [1:0]            sync_q;
  logic                  rxd_s;
  logic                  rxd_d;
  logic                  fall;
  logic                  active;
  logic [BAUD_W-1:0]     baud_cnt;
  logic [3:0]            bit_idx;
  logic [BYTE_WIDTH-1:0] data_q;
  logic                  perr_q;
  logic                  valid_q;

  assign rxd_s = sync_q[1];
  assign fall  = rxd_d & ~rxd_s;

  assign link.rx_valid = valid_q;
  assign link.rx_byte  = data_q;
  assign link.rx_perr  = perr_q;

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      sync_q   <= 2'b11;
      rxd_d    <= 1'b1;
      active   <= 1'b0;
      baud_cnt <= '0;
      bit_idx  <= '0;
      perr_q   <= 1'b0;
      valid_q  <= 1'b0;
    end
    else
    begin
      sync_q  <= {sync_q[0], rxd};
      rxd_d   <= rxd_s;
      valid_q <= 1'b0;
      if (!active)
      begin
        if (link.rx_arm && fall)
        begin
          active   <= 1'b1;
          baud_cnt <= '0;
          bit_idx  <= '0;
        end
      end
      else
      begin
        if (baud_cnt == BAUD_MAX)
        begin
          baud_cnt <= '0;
          bit_idx  <= bit_idx + 1'b1;
        end
        else
          baud_cnt <= baud_cnt + 1'b1;

        // mid-bit sample point
        if (baud_cnt == HALF)
        begin
          if (bit_idx == '0)
          begin
            if (rxd_s)
              active <= 1'b0;  // glitch, not a start bit
          end
          else if (bit_idx == PAR_BIT)
            perr_q <= (rxd_s != ~^data_q);
          else if (bit_idx == STOP_BIT)
          begin
            valid_q <= 1'b1;
            active  <= 1'b0;
          end
        end
      end
    end
  end

  always_ff @(posedge clk)
  begin
    if (active && baud_cnt == HALF && bit_idx != '0 && bit_idx < PAR_BIT)
      data_q <= {rxd_s, data_q[BYTE_WIDTH-1:1]};  // lsb first
  end

endmodule

/* rtl/uart_frame_tx.sv */
`timescale 1ns/1ps

module uart_frame_tx
  import uart_bridge_pkg::*;
#(
  parameter int CLKS_PER_BIT = 434
) (
  input  logic   clk,
  input  logic   rst_n,
  uart_link_if.tx link,
  output logic   txd
);

  localparam int FRAME_BITS = BYTE_WIDTH + 3;  // start, data, parity, stop
  localparam int BAUD_W     = $clog2(CLKS_PER_BIT);

  localparam logic [BAUD_W-1:0] BAUD_MAX = BAUD_W'(CLKS_PER_BIT - 1);
  localparam logic [3:0]        LAST_BIT = 4'(FRAME_BITS - 1);

  logic                  busy;
  logic [BAUD_W-1:0]     baud_cnt;
  logic [3:0]            bit_idx;
  logic [FRAME_BITS-1:0] shreg;

  assign link.tx_busy = busy;
  assign txd          = busy ? shreg[0] : 1'b1;  // line idles high

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      busy     <= 1'b0;
      baud_cnt <= '0;
      bit_idx  <= '0;
    end
    else if (!busy)
    begin
      if (link.tx_start)
      begin
        busy     <= 1'b1;
        baud_cnt <= '0;
        bit_idx  <= '0;
      end
    end
    else if (baud_cnt == BAUD_MAX)
    begin
      baud_cnt <= '0;
      if (bit_idx == LAST_BIT)
        busy <= 1'b0;  // end of stop bit
      else
        bit_idx <= bit_idx + 1'b1;
    end
    else
      baud_cnt <= baud_cnt + 1'b1;
  end

  always_ff @(posedge clk)
  begin
    if (!busy && link.tx_start)
      shreg <= {1'b1, ~^link.tx_byte, link.tx_byte, 1'b0};  // odd parity
    else if (busy && baud_cnt == BAUD_MAX)
      shreg <= {1'b1, shreg[FRAME_BITS-1:1]};
  end

endmodule

/* rtl/uart_link_if.sv */
`timescale 1ns/1ps

interface uart_link_if
  import uart_bridge_pkg::*;
();

  // transmit side
  logic                  tx_start;  // accepted only while tx_busy is low
  logic [BYTE_WIDTH-1:0] tx_byte;
  logic                  tx_busy;

  // receive side
  logic                  rx_arm;
  logic                  rx_valid;  // single cycle pulse at mid stop bit
  logic [BYTE_WIDTH-1:0] rx_byte;
  logic                  rx_perr;

  modport seq (
    output tx_start, tx_byte, rx_arm,
    input  tx_busy, rx_valid, rx_byte, rx_perr
  );

  modport tx (
    input  tx_start, tx_byte,
    output tx_busy
  );

  modport rx (
    input  rx_arm,
    output rx_valid, rx_byte, rx_perr
  );

endinterface

/* tb/tb_clk_gen.sv */
`timescale 1ns/1ps

module tb_clk_gen #(
  parameter real PERIOD       = 8.0,
  parameter int  RESET_CYCLES = 8
) (
  output logic clk,
  output logic rst_n
);

  initial
  begin
    clk = 1'b0;
    forever #(PERIOD / 2.0) clk = ~clk;
  end

  initial
  begin
    rst_n = 1'b0;
    repeat (RESET_CYCLES) @(posedge clk);
    rst_n <= 1'b1;
  end

endmodule

/* tb/uart_bridge_checker.sv */
`timescale 1ns/1ps

module uart_bridge_checker (
  input logic clk,
  input logic rst_n,
  input logic txd,
  input logic tx_busy,
  input logic tx_start,
  input logic pready,
  input logic seq_busy,
  input logic seq_done
);

  int violations = 0;  // summed into the final result

  // ############################################################
  // serial line and link handshake
  // ############################################################
  idle_line_high: assert property (@(posedge clk) disable iff (!rst_n) !tx_busy |-> txd)
  else
  begin
    $error("txd is low while the transmitter is idle");
    violations++;
  end

  start_when_free: assert property (@(posedge clk) disable iff (!rst_n) tx_start |-> !tx_busy)
  else
  begin
    $error("tx_start raised while the transmitter is busy");
    violations++;
  end

  // ############################################################
  // apb and sequencer
  // ############################################################
  apb_no_wait: assert property (@(posedge clk) disable iff (!rst_n) pready)
  else
  begin
    $error("pready dropped low");
    violations++;
  end

  done_inside_busy: assert property (@(posedge clk) disable iff (!rst_n) seq_done |-> seq_busy)
  else
  begin
    $error("seq_done pulsed while the sequencer is idle");
    violations++;
  end

endmodule

/* tb/uart_bridge_tb.sv */
`timescale 1ns/1ps

module uart_bridge_tb
  import uart_bridge_pkg::*;
();

  localparam int CLKS_PER_BIT = 16;
  localparam int GAP_CYCLES   = 40;
  localparam int RESP_TIMEOUT = 400;
  localparam int N_WR         = 8;
  localparam int N_RD         = 6;
  localparam int N_CMDS       = N_WR + N_RD + 3;  // plus busy, parity and timeout cases
  localparam int WATCHDOG     = N_CMDS * (3 * 11 * CLKS_PER_BIT + GAP_CYCLES + RESP_TIMEOUT + 200);
  localparam int POLL_LIMIT   = 400;

  localparam int MODE_NORMAL  = 0;
  localparam int MODE_BAD_PAR = 1;
  localparam int MODE_SILENT  = 2;

  logic        clk;
  logic        rst_n;
  logic        psel;
  logic        penable;
  logic        pwrite;
  logic [3:0]  paddr;
  logic [31:0] pwdata;
  logic [31:0] prdata;
  logic        pready;
  logic        pslverr;
  logic        txd;
  logic        rxd;

  integer     seed       = 32'h3698;
  int         errors     = 0;
  int         checks     = 0;
  int         resp_mode  = MODE_NORMAL;
  logic       responding = 1'b0;  // remote device is driving rxd
  logic [7:0] model_mem [128];
  logic [7:0] sb_mem [128];
  logic [7:0] seen_frames [$];
  logic [6:0] written [$];

  tb_clk_gen #(
    .PERIOD       (8.0),
    .RESET_CYCLES (8)
  ) tb_clk_gen_inst (
    .clk   (clk),
    .rst_n (rst_n)
  );

  uart_bridge_top #(
    .CLKS_PER_BIT (CLKS_PER_BIT),
    .GAP_CYCLES   (GAP_CYCLES),
    .RESP_TIMEOUT (RESP_TIMEOUT)
  ) uart_bridge_top_inst (
    .clk     (clk),
    .rst_n   (rst_n),
    .psel    (psel),
    .penable (penable),
    .pwrite  (pwrite),
    .paddr   (paddr),
    .pwdata  (pwdata),
    .prdata  (prdata),
    .pready  (pready),
    .pslverr (pslverr),
    .txd     (txd),
    .rxd     (rxd)
  );

  bind uart_bridge_top uart_bridge_checker uart_bridge_checker_inst (
    .clk      (clk),
    .rst_n    (rst_n),
    .txd      (txd),
    .tx_busy  (link.tx_busy),
    .tx_start (link.tx_start),
    .pready   (pready),
    .seq_busy (seq_busy),
    .seq_done (seq_done)
  );

  function automatic logic [7:0] fill_pattern(input int a);
    return 8'(a * 37) ^ 8'h5c;
  endfunction

  task automatic check_value(input string name, input logic [31:0] expected,
                             input logic [31:0] actual);
    checks++;
    if (actual !== expected)
    begin
      $display("Fail %s: expected %h, actual %h", name, expected, actual);
      errors++;
    end
  endtask

  // ############################################################
  // apb driver
  // ############################################################
  task automatic apb_access(input logic wr, input logic [3:0] addr, input logic [31:0] wdata,
                            output logic [31:0] rdata, output logic err);
    @(posedge clk);
    psel    <= 1'b1;
    penable <= 1'b0;
    pwrite  <= wr;
    paddr   <= addr;
    pwdata  <= wdata;
    @(posedge clk);
    penable <= 1'b1;
    @(negedge clk);  // access phase, outputs settled
    rdata = prdata;
    err   = pslverr;
    @(posedge clk);
    psel    <= 1'b0;
    penable <= 1'b0;
  endtask

  task automatic wait_done(input string name, output logic [31:0] status);
    logic [31:0] st;
    logic        err;
    int          polls;
    st    = '0;
    polls = 0;
    while (!st[ST_DONE] && polls < POLL_LIMIT)
    begin
      apb_access(1'b0, REG_STATUS, 32'h0, st, err);
      polls++;
    end
    if (!st[ST_DONE])
    begin
      $display("%s: bridge never reported done after %0d status polls", name, polls);
      errors++;
    end
    status = st;
  endtask

  task automatic run_command(input string name, input logic [15:0] cmd,
                             output logic [31:0] status);
    logic [31:0] rd;
    logic        err;
    wait (!responding);
    seen_frames.delete();
    apb_access(1'b1, REG_CMD, {16'h0, cmd}, rd, err);
    check_value({name, " pslverr"}, 32'h0, err);
    wait_done(name, status);
  endtask

  task automatic check_frames(input string name, input logic [15:0] cmd, input int count);
    check_value({name, " frame count"}, count, seen_frames.size());
    if (seen_frames.size() >= 1)
      check_value({name, " high byte"}, cmd[15:8], seen_frames[0]);
    if (count == 2 && seen_frames.size() >= 2)
      check_value({name, " low byte"}, cmd[7:0], seen_frames[1]);
  endtask

  // ############################################################
  // remote device
  // ############################################################
  task automatic receive_frame(output logic [7:0] data);
    logic par;
    int   i;
    @(negedge txd);
    repeat (CLKS_PER_BIT / 2) @(negedge clk);  // middle of start bit
    check_value("frame start bit", 32'h0, txd);
    for (i = 0; i < 8; i++)
    begin
      repeat (CLKS_PER_BIT) @(negedge clk);
      data[i] = txd;  // lsb first
    end
    repeat (CLKS_PER_BIT) @(negedge clk);
    par = txd;
    check_value("frame parity bit", ~^data, par);
    repeat (CLKS_PER_BIT) @(negedge clk);
    check_value("frame stop bit", 32'h1, txd);
  endtask

  task automatic send_response(input logic [7:0] data, input logic bad_par);
    logic [10:0] frame;
    int          delay;
    int          i;
    responding = 1'b1;
    delay = 70 + ({$random(seed)} % 128);  // answers after the receiver is armed
    frame = {1'b1, (~^data) ^ bad_par, data, 1'b0};
    repeat (delay) @(posedge clk);
    for (i = 0; i < 11; i++)
    begin
      rxd <= frame[i];
      repeat (CLKS_PER_BIT) @(posedge clk);
    end
    responding = 1'b0;
  endtask

  initial
  begin : remote_device
    logic [7:0] rx;
    logic       wr_pending;
    logic [6:0] wr_addr;
    int         a;
    for (a = 0; a < 128; a++)
    begin
      model_mem[a] = fill_pattern(a);
      sb_mem[a]    = fill_pattern(a);
    end
    wr_pending = 1'b0;
    wr_addr    = '0;
    @(posedge rst_n);
    forever
    begin
      receive_frame(rx);
      seen_frames.push_back(rx);
      if (wr_pending)
      begin
        model_mem[wr_addr] = rx;
        wr_pending         = 1'b0;
      end
      else if (rx[7])
      begin
        wr_pending = 1'b1;
        wr_addr    = rx[6:0];
      end
      else if (resp_mode != MODE_SILENT)
        send_response(model_mem[rx[6:0]], resp_mode == MODE_BAD_PAR);
    end
  end

  // ############################################################
  // stimulus and scoreboard
  // ############################################################
  initial
  begin : main
    logic [31:0] rd;
    logic [31:0] st;
    logic        err;
    logic [15:0] cmd;
    logic [6:0]  addr;
    int          n;
    int          fails;
    psel    = 1'b0;
    penable = 1'b0;
    pwrite  = 1'b0;
    paddr   = '0;
    pwdata  = '0;
    rxd     = 1'b1;
    @(posedge rst_n);
    @(negedge clk);
    check_value("reset txd", 32'h1, txd);
    apb_access(1'b0, REG_STATUS, 32'h0, rd, err);
    check_value("reset status", 32'h0, rd);

    for (n = 0; n < N_WR; n++)
    begin
      addr = 7'($random(seed));
      cmd  = {1'b1, addr, 8'($random(seed))};
      run_command("write", cmd, st);
      check_frames("write", cmd, 2);
      check_value("write status", 1 << ST_DONE, st);
      sb_mem[addr] = cmd[7:0];
      written.push_back(addr);
    end

    // second command while the first is still running
    addr = 7'($random(seed));
    cmd  = {1'b1, addr, 8'($random(seed))};
    wait (!responding);
    seen_frames.delete();
    apb_access(1'b1, REG_CMD, {16'h0, cmd}, rd, err);
    check_value("busy first pslverr", 32'h0, err);
    apb_access(1'b1, REG_CMD, {16'h0, ~cmd}, rd, err);
    check_value("busy second pslverr", 32'h1, err);
    wait_done("busy", st);
    check_frames("busy", cmd, 2);
    check_value("busy status", 1 << ST_DONE, st);
    apb_access(1'b0, REG_CMD, 32'h0, rd, err);
    check_value("busy command kept", cmd, rd);
    sb_mem[addr] = cmd[7:0];
    written.push_back(addr);

    for (n = 0; n < N_RD; n++)
    begin
      addr = written[{$random(seed)} % written.size()];
      cmd  = {1'b0, addr, 8'($random(seed))};
      run_command("read", cmd, st);
      check_frames("read", cmd, 1);
      check_value("read status", 1 << ST_DONE, st);
      apb_access(1'b0, REG_RDATA, 32'h0, rd, err);
      check_value("read data", sb_mem[addr], rd);
    end

    resp_mode = MODE_BAD_PAR;
    addr = written[{$random(seed)} % written.size()];
    cmd  = {1'b0, addr, 8'h00};
    run_command("parity", cmd, st);
    check_value("parity status", (1 << ST_DONE) | (1 << ST_PERR), st);
    apb_access(1'b0, REG_RDATA, 32'h0, rd, err);
    check_value("parity data", sb_mem[addr], rd);

    resp_mode = MODE_SILENT;
    cmd = {1'b0, written[0], 8'h00};
    run_command("timeout", cmd, st);
    check_value("timeout status", (1 << ST_DONE) | (1 << ST_TMO), st);
    resp_mode = MODE_NORMAL;

    apb_access(1'b0, 4'hc, 32'h0, rd, err);
    check_value("bad offset pslverr", 32'h1, err);

    fails = uart_bridge_top_inst.uart_bridge_checker_inst.violations;
    $display("checks %0d, errors %0d, assertion failures %0d", checks, errors, fails);
    if (errors == 0 && fails == 0)
      $display("** PASS **");
    else
      $display("** FAIL **");
    $finish;
  end

  initial
  begin : watchdog
    repeat (WATCHDOG) @(posedge clk);
    $display("timeout: run did not finish within %0d cycles", WATCHDOG);
    $display("checks %0d, errors %0d", checks, errors);
    $display("** FAIL **");
    $finish;
  end

endmodule
